// ==== verilog.f ====
hw/isa_pkg.sv
hw/fetch_pkg.sv
hw/insn_length.sv
hw/fetch_unpacker.sv
hw/parcel_queue.sv
hw/insn_aligner.sv
hw/fetch_align_top.sv
tb/tb_fetch_align.sv

// ==== tb/tb_fetch_align.sv ====
// Fetch alignment testbench with stimulus table, LFSR, stream model, checker and watchdog
`timescale 1ns/10ps
`default_nettype none

module tb_fetch_align
  import isa_pkg::*;
  import fetch_pkg::*;
();

  localparam int CLK_PERIOD  = 40;
  localparam int DRIVE_DELAY = 2;

  logic          clk;
  logic          arst_n;
  logic          flush;
  logic          blk_valid;
  fetch_block_t  blk;
  logic          blk_busy;
  logic          insn_valid;
  aligned_insn_t insn;

  // Stimulus table with one row per instruction of the stream
  string         tab_name[$];
  logic [7:0]    tab_op[$];
  int            tab_len[$];
  int            tab_start[$];
  bit            tab_flush[$];

  // Fetch blocks to drive and for each the instruction count to reach before a flush
  // A value of -1 means no flush follows that block
  fetch_block_t  blk_list[$];
  int            flush_wait[$];

  // Model of the instructions still expected in stream order
  aligned_insn_t exp_q[$];
  string         exp_name[$];
  int            exp_total;
  int            checked_cnt;
  bit            built;
  int            limit_cycles;

  // Stream builder state
  logic [31:0]   lfsr;
  fetch_block_t  cur_blk;
  int            cur_pos;
  bit            blk_open;

  fetch_align_top #(
    .QUEUE_DEPTH (16)
  ) u_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .flush      (flush),
    .blk_valid  (blk_valid),
    .blk        (blk),
    .blk_busy   (blk_busy),
    .insn_valid (insn_valid),
    .insn       (insn)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // ==================================================
  // Failure reporting
  // ==================================================

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string name, input aligned_insn_t exp,
                                 input aligned_insn_t act);
    $display("** Error [%s]: expected len %0d word %h, actual len %0d word %h",
             name, exp.len, exp.word, act.len, act.word);
    stop_with_failure("The aligned instruction differs from the stream model");
  endtask

  // ==================================================
  // Random bytes and stream construction
  // ==================================================

  // Galois LFSR with the polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // One LFSR step per bit
  task automatic rand_byte(output logic [7:0] b);
    for (int k = 0; k < 8; k++) begin
      lfsr = lfsr_next(lfsr);
      b[k] = lfsr[0];
    end
  endtask

  task automatic add_entry(input string name, input logic [7:0] op, input int len,
                           input int start, input bit fl);
    tab_name.push_back(name);
    tab_op.push_back(op);
    tab_len.push_back(len);
    tab_start.push_back(start);
    tab_flush.push_back(fl);
  endtask

  // Parcels go into the open block and a full block joins the drive list
  task automatic append_parcel(input parcel_t p);
    if (!blk_open) begin
      cur_blk  = '0;
      cur_pos  = 0;
      blk_open = 1'b1;
    end
    cur_blk.parcels[cur_pos] = p;
    cur_pos++;
    if (cur_pos == 4) begin
      blk_list.push_back(cur_blk);
      flush_wait.push_back(-1);
      blk_open = 1'b0;
    end
  endtask

  // Builds one instruction where a dropped one only gets its first half into the stream
  task automatic emit_insn(input string name, input logic [7:0] op, input int len,
                           input bit keep);
    int            n;
    logic [63:0]   word;
    logic [7:0]    b;
    aligned_insn_t exp;
    word      = '0;
    word[7:0] = op;
    for (int i = 1; i < len; i++) begin
      rand_byte(b);
      word[i*8 +: 8] = b;
    end
    n = keep ? len / 2 : len / 4;
    for (int i = 0; i < n; i++) begin
      append_parcel(word[i*16 +: 16]);
    end
    if (keep) begin
      exp.word = word;
      exp.len  = 4'(len);
      exp_q.push_back(exp);
      exp_name.push_back(name);
      exp_total++;
    end
  endtask

  // Opens a branch target block whose parcels below the start are junk that must never show up
  task automatic open_block_at(input int s);
    logic [7:0] lo;
    logic [7:0] hi;
    // Pad the current block with NOPs so the parcel stream stays gap free
    while (blk_open) begin
      emit_insn("nop_pad", NOP, 2, 1'b1);
    end
    cur_blk       = '0;
    cur_blk.start = 2'(s);
    for (int i = 0; i < s; i++) begin
      rand_byte(lo);
      rand_byte(hi);
      cur_blk.parcels[i] = {hi, lo};
    end
    cur_pos  = s;
    blk_open = 1'b1;
  endtask

  task automatic build_stream();
    for (int i = 0; i < tab_op.size(); i++) begin
      if (tab_flush[i]) begin
        open_block_at(tab_start[i]);
        emit_insn(tab_name[i], tab_op[i], tab_len[i], 1'b0);
        // Everything emitted so far has to drain before the flush
        flush_wait[flush_wait.size() - 1] = exp_total;
      end else begin
        if (tab_start[i] != 0) begin
          open_block_at(tab_start[i]);
        end
        emit_insn(tab_name[i], tab_op[i], tab_len[i], 1'b1);
      end
    end
    while (blk_open) begin
      emit_insn("nop_pad", NOP, 2, 1'b1);
    end
  endtask

  // Name, opcode, length from the ISA table, start index, flush flag
  task automatic fill_table();
    add_entry("len2_nop", NOP, 2, 0, 1'b0);
    add_entry("len2_rts", RTS, 2, 0, 1'b0);
    add_entry("len2_brk", BRK, 2, 0, 1'b0);
    add_entry("len2_push", PUSH, 2, 0, 1'b0);
    add_entry("len2_pop", POP, 2, 0, 1'b0);
    add_entry("len2_exi8", EXI8, 2, 0, 1'b0);
    add_entry("len4_addi", ADDI, 4, 0, 1'b0);
    add_entry("len4_andi", ANDI, 4, 0, 1'b0);
    add_entry("len4_ori", ORI, 4, 0, 1'b0);
    add_entry("len4_cmpi", CMPI, 4, 0, 1'b0);
    add_entry("len4_jeqz", JEQZ, 4, 0, 1'b0);
    add_entry("len4_ldbx", LDBX, 4, 0, 1'b0);
    add_entry("len4_stbx", STBX, 4, 0, 1'b0);
    add_entry("len4_exi24", EXI24, 4, 0, 1'b0);
    add_entry("len6_r2", R2, 6, 0, 1'b0);
    add_entry("len6_jmp", JMP, 6, 0, 1'b0);
    add_entry("len6_addil", ADDIL, 6, 0, 1'b0);
    add_entry("len6_ldo", LDO, 6, 0, 1'b0);
    add_entry("len6_sto", STO, 6, 0, 1'b0);
    add_entry("len6_exi40", EXI40, 6, 0, 1'b0);
    add_entry("len8_exi56", EXI56, 8, 0, 1'b0);
    add_entry("len8_exim", EXIM, 8, 0, 1'b0);
    add_entry("len6_range_d", 8'hD5, 6, 0, 1'b0);
    add_entry("len6_range_e", 8'hEC, 6, 0, 1'b0);
    add_entry("len2_unlisted", 8'h7E, 2, 0, 1'b0);
    // Mixed lengths that straddle block boundaries
    add_entry("mix_exim", EXIM, 8, 0, 1'b0);
    add_entry("mix_r2", R2, 6, 0, 1'b0);
    add_entry("mix_nop", NOP, 2, 0, 1'b0);
    add_entry("mix_ldo", LDO, 6, 0, 1'b0);
    add_entry("mix_exi56", EXI56, 8, 0, 1'b0);
    // Branch targets in the middle of a block
    add_entry("start1_jmp", JMP, 6, 1, 1'b0);
    add_entry("start3_addi", ADDI, 4, 3, 1'b0);
    add_entry("start2_exi56", EXI56, 8, 2, 1'b0);
    // Half of an 8-byte instruction followed by a redirect
    add_entry("flush_exim", EXIM, 8, 2, 1'b1);
    add_entry("fresh_cmpi", CMPI, 4, 0, 1'b0);
    add_entry("fresh_exi40", EXI40, 6, 0, 1'b0);
    add_entry("fresh_push", PUSH, 2, 0, 1'b0);
    add_entry("fresh_range", 8'hE0, 6, 0, 1'b0);
    add_entry("fresh_exim", EXIM, 8, 0, 1'b0);
  endtask

  // ==================================================
  // Driving
  // ==================================================

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  // busy only depends on registered state, so its value now holds at the coming edge
  task automatic send_block(input fetch_block_t b);
    bit taken;
    blk_valid = 1'b1;
    blk       = b;
    taken     = 1'b0;
    while (!taken) begin
      taken = !blk_busy;
      next_cycle();
    end
  endtask

  task automatic wait_checked(input int n);
    while (checked_cnt < n) begin
      next_cycle();
    end
  endtask

  // ==================================================
  // Checker sampled mid cycle where outputs are stable
  // ==================================================

  always @(negedge clk) begin
    aligned_insn_t exp;
    string         name;
    if (arst_n === 1'b1) begin
      assert (!$isunknown(insn_valid))
        else stop_with_failure("insn_valid is unknown after reset");
    end
    if (insn_valid === 1'b1) begin
      assert (exp_q.size() > 0)
        else stop_with_failure("An instruction came out when none was expected");
      exp  = exp_q.pop_front();
      name = exp_name.pop_front();
      assert (insn === exp)
        else report_mismatch(name, exp, insn);
      checked_cnt++;
    end
  end

  // Watchdog allows eight cycles per parcel plus a margin for reset and flushes
  initial begin
    wait (built);
    limit_cycles = blk_list.size() * 4 * 8 + 200;
    repeat (limit_cycles) @(posedge clk);
    stop_with_failure($sformatf("Timeout: outputs stalled, %0d of %0d instructions seen",
                                checked_cnt, exp_total));
  end

  initial begin
    arst_n      = 1'b0;
    flush       = 1'b0;
    blk_valid   = 1'b0;
    blk         = '0;
    lfsr        = 32'hb03f_8fed;
    cur_blk     = '0;
    cur_pos     = 0;
    blk_open    = 1'b0;
    exp_total   = 0;
    checked_cnt = 0;
    built       = 1'b0;
    fill_table();
    build_stream();
    built = 1'b1;

    repeat (3) @(posedge clk);
    #DRIVE_DELAY;
    arst_n = 1'b1;

    // The DUT stays idle after reset and the checker flags any stray output
    repeat (6) begin
      assert (insn_valid === 1'b0 && blk_busy === 1'b0)
        else stop_with_failure("The DUT is not idle after reset");
      next_cycle();
    end

    // Blocks go back to back, so blk_busy alone paces the source
    for (int i = 0; i < blk_list.size(); i++) begin
      send_block(blk_list[i]);
      if (flush_wait[i] >= 0) begin
        blk_valid = 1'b0;
        wait_checked(flush_wait[i]);
        while (blk_busy === 1'b1) begin
          next_cycle();
        end
        repeat (3) next_cycle();
        // The half instruction sits in the queue until this clears it
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
      end
    end
    blk_valid = 1'b0;

    wait_checked(exp_total);
    repeat (10) next_cycle();

    // With the stream drained the queue is empty and the unpacker idle
    if (blk_busy === 1'b0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      stop_with_failure("blk_busy is still high after the whole stream drained");
    end
  end

endmodule

`default_nettype wire

// ==== hw/fetch_align_top.sv ====
// Fetch alignment top level: fetch unpacker, parcel queue and instruction aligner
`timescale 1ns/10ps
`default_nettype none

module fetch_align_top
  import isa_pkg::*;
  import fetch_pkg::*;
#(
  parameter int QUEUE_DEPTH = 16
) (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          flush,
  input  logic          blk_valid,
  input  fetch_block_t  blk,
  output logic          blk_busy,
  output logic          insn_valid,
  output aligned_insn_t insn
);

  localparam int CNT_W = $clog2(QUEUE_DEPTH) + 1;

  // Producer to queue
  logic           push;
  parcel_t        push_parcel;
  logic [CNT_W-1:0] free_cnt;
  // Queue to consumer and back
  parcel_window_t window;
  logic [CNT_W-1:0] count;
  logic           pop;
  logic [2:0]     pop_cnt;

  fetch_unpacker #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_fetch_unpacker (
    .clk         (clk),
    .arst_n      (arst_n),
    .flush       (flush),
    .blk_valid   (blk_valid),
    .blk         (blk),
    .free_cnt    (free_cnt),
    .blk_busy    (blk_busy),
    .push        (push),
    .push_parcel (push_parcel)
  );

  parcel_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_parcel_queue (
    .clk         (clk),
    .arst_n      (arst_n),
    .flush       (flush),
    .push        (push),
    .push_parcel (push_parcel),
    .pop         (pop),
    .pop_cnt     (pop_cnt),
    .window      (window),
    .count       (count),
    .free_cnt    (free_cnt)
  );

  // The downstream decoder always accepts, so the aligner never stalls
  insn_aligner #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_insn_aligner (
    .clk        (clk),
    .arst_n     (arst_n),
    .flush      (flush),
    .window     (window),
    .count      (count),
    .pop        (pop),
    .pop_cnt    (pop_cnt),
    .insn_valid (insn_valid),
    .insn       (insn)
  );

endmodule

`default_nettype wire

// ==== hw/insn_aligner.sv ====
// Instruction aligner: decodes the head length, pops whole instructions and registers them
`timescale 1ns/10ps
`default_nettype none

module insn_aligner
  import isa_pkg::*;
  import fetch_pkg::*;
#(
  parameter int QUEUE_DEPTH = 16
) (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         flush,
  input  parcel_window_t               window,
  input  logic [$clog2(QUEUE_DEPTH):0] count,
  output logic                         pop,
  output logic [2:0]                   pop_cnt,
  output logic                         insn_valid,
  output aligned_insn_t                insn
);

  insn_len_t     len;
  // Parcels needed by the instruction at the head, 1 to 4
  logic [2:0]    need;
  logic          take;
  logic [63:0]   raw_word;
  logic [63:0]   masked_word;
  logic          valid_q;
  aligned_insn_t insn_q;

  // ==================================================
  // Length and pop decision
  // ==================================================

  // The opcode always sits in the low byte of the head parcel
  insn_length u_insn_length (
    .opcode (window[0][7:0]),
    .len    (len)
  );

  // Lengths are even, so half the byte count is the parcel count
  assign need = len[3:1];

  // Wait until every parcel of the head instruction has arrived
  assign take    = (count >= ($clog2(QUEUE_DEPTH)+1)'(need)) && !flush;
  assign pop     = take;
  assign pop_cnt = need;

  // ==================================================
  // Instruction assembly
  // ==================================================

  // The packed window already lays out bytes in address order
  assign raw_word = window;

  // Bytes past the length belong to the next instruction or are stale
  always_comb begin
    for (int b = 0; b < 8; b++) begin
      if (4'(b) < len) begin
        masked_word[b*8 +: 8] = raw_word[b*8 +: 8];
      end else begin
        masked_word[b*8 +: 8] = 8'h00;
      end
    end
  end

  // One instruction per cycle, valid follows the pop by one edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= take;
    end
  end

  // Instruction payload register
  always_ff @(posedge clk) begin
    if (take) begin
      insn_q.word <= masked_word;
      insn_q.len  <= len;
    end
  end

  assign insn_valid = valid_q;
  assign insn       = insn_q;

endmodule

`default_nettype wire

// ==== hw/parcel_queue.sv ====
// Parcel queue: circular buffer with a four parcel head window and a 1 to 4 parcel pop
`timescale 1ns/10ps
`default_nettype none

module parcel_queue
  import isa_pkg::*;
  import fetch_pkg::*;
#(
  parameter int QUEUE_DEPTH = 16
) (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         flush,
  input  logic                         push,
  input  parcel_t                      push_parcel,
  input  logic                         pop,
  input  logic [2:0]                   pop_cnt,
  output parcel_window_t               window,
  output logic [$clog2(QUEUE_DEPTH):0] count,
  output logic [$clog2(QUEUE_DEPTH):0] free_cnt
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);

  // Parcel storage
  parcel_t                mem [QUEUE_DEPTH];
  // Pointers wrap naturally since the depth is a power of two
  logic [PTR_W-1:0]       rd_ptr_q;
  logic [PTR_W-1:0]       wr_ptr_q;
  // One bit wider than the pointers so that a full queue is distinct from empty
  logic [PTR_W:0]         count_q;
  logic [PTR_W:0]         pop_amt;
  logic [PTR_W:0]         push_amt;

  assign pop_amt  = pop ? (PTR_W+1)'(pop_cnt) : '0;
  assign push_amt = push ? (PTR_W+1)'(1) : '0;

  // ==================================================
  // Pointers and occupancy
  // ==================================================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush) begin
      // Redirect, everything held is stale
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // The aligner never pops more than the count it was shown
      rd_ptr_q <= rd_ptr_q + pop_amt[PTR_W-1:0];
      wr_ptr_q <= wr_ptr_q + push_amt[PTR_W-1:0];
      count_q  <= count_q + push_amt - pop_amt;
    end
  end

  // Storage write, the entry is only visible once count covers it
  always_ff @(posedge clk) begin
    if (push && !flush) begin
      mem[wr_ptr_q] <= push_parcel;
    end
  end

  // ==================================================
  // Head window
  // ==================================================

  // Slots at or beyond count show whatever the storage last held
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      window[i] = mem[rd_ptr_q + PTR_W'(i)];
    end
  end

  assign count    = count_q;
  assign free_cnt = (PTR_W+1)'(QUEUE_DEPTH) - count_q;

endmodule

`default_nettype wire

// ==== hw/fetch_unpacker.sv ====
// Fetch unpacker: accepts fetch blocks and pushes their parcels into the parcel queue
`timescale 1ns/10ps
`default_nettype none

module fetch_unpacker
  import isa_pkg::*;
  import fetch_pkg::*;
#(
  parameter int QUEUE_DEPTH = 16
) (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         flush,
  input  logic                         blk_valid,
  input  fetch_block_t                 blk,
  input  logic [$clog2(QUEUE_DEPTH):0] free_cnt,
  output logic                         blk_busy,
  output logic                         push,
  output parcel_t                      push_parcel
);

  // Latched block, only read while active_q is set
  fetch_block_t blk_q;
  // Index of the parcel pushed in the current cycle
  logic [1:0]   idx_q;
  // High while parcels of the latched block remain to be pushed
  logic         active_q;
  logic         accept;

  // A whole block is at most four parcels, so four free entries always suffice
  assign blk_busy = active_q || (free_cnt < 4);
  assign accept   = blk_valid && !blk_busy;

  // Parcels of a block that is being flushed never reach the queue
  assign push        = active_q && !flush;
  assign push_parcel = blk_q.parcels[idx_q];

  // ==================================================
  // Unpack state
  // ==================================================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      active_q <= 1'b0;
      idx_q    <= 2'd0;
    end else if (accept) begin
      // A block taken in a flush cycle belongs to the new stream
      active_q <= 1'b1;
      idx_q    <= blk.start;
    end else if (flush) begin
      active_q <= 1'b0;
    end else if (active_q) begin
      // Parcel 3 is the last one of every block
      if (idx_q == 2'd3) begin
        active_q <= 1'b0;
      end else begin
        idx_q <= idx_q + 2'd1;
      end
    end
  end

  // Block payload register
  always_ff @(posedge clk) begin
    if (accept) begin
      blk_q <= blk;
    end
  end

endmodule

`default_nettype wire

// ==== hw/insn_length.sv ====
// Opcode length decoder: maps the first opcode byte to the instruction length in bytes
`timescale 1ns/10ps
`default_nettype none

module insn_length
  import isa_pkg::*;
(
  input  logic [7:0] opcode,
  output insn_len_t  len
);

  // Purely combinational lookup, the wildcard arm covers the D and E rows
  always_comb begin
    casez (opcode)
      // Short forms
      BRK:     len = 4'd2;
      NOP:     len = 4'd2;
      RTS:     len = 4'd2;
      PUSH:    len = 4'd2;
      POP:     len = 4'd2;
      EXI8:    len = 4'd2;
      // Register and short immediate forms
      ADDI:    len = 4'd4;
      ANDI:    len = 4'd4;
      ORI:     len = 4'd4;
      CMPI:    len = 4'd4;
      JEQZ:    len = 4'd4;
      LDBX:    len = 4'd4;
      STBX:    len = 4'd4;
      EXI24:   len = 4'd4;
      // Long immediate, jump and displacement forms
      R2:      len = 4'd6;
      JMP:     len = 4'd6;
      ADDIL:   len = 4'd6;
      LDO:     len = 4'd6;
      STO:     len = 4'd6;
      EXI40:   len = 4'd6;
      // Full width constant prefixes
      EXI56:   len = 4'd8;
      EXIM:    len = 4'd8;
      // Whole rows of six byte opcodes
      8'hD?:   len = 4'd6;
      8'hE?:   len = 4'd6;
      // Anything not listed is treated as a two byte instruction
      default: len = 4'd2;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/fetch_pkg.sv ====
// Fetch package: fetch block struct, aligned instruction struct and parcel window type
`default_nettype none

package fetch_pkg;

  import isa_pkg::*;

  // A 64-bit fetch block as delivered by instruction fetch
  // Parcel 0 holds the lowest address, start selects the first valid parcel
  typedef struct packed {
    logic [1:0]    start;
    parcel_t [3:0] parcels;
  } fetch_block_t;

  // One instruction after alignment
  // The first byte is in bits 7:0 and bytes past len are zero
  typedef struct packed {
    insn_len_t   len;
    logic [63:0] word;
  } aligned_insn_t;

  // Four parcels seen at the queue head, slot 0 is the oldest
  typedef parcel_t [3:0] parcel_window_t;

endpackage

`default_nettype wire

// ==== hw/isa_pkg.sv ====
// ISA package: opcode byte constants, instruction parcel type and instruction length type
`default_nettype none

package isa_pkg;

  // ==================================================
  // Basic instruction types
  // ==================================================

  // One 16-bit parcel, the opcode byte is the low byte
  typedef logic [15:0] parcel_t;

  // Instruction length in bytes, only 2, 4, 6 and 8 are produced
  typedef logic [3:0] insn_len_t;

  // ==================================================
  // Opcode bytes
  // ==================================================

  // Two byte instructions
  localparam logic [7:0] BRK   = 8'h00;
  localparam logic [7:0] EXI8  = 8'h50;
  localparam logic [7:0] NOP   = 8'hF1;
  localparam logic [7:0] RTS   = 8'hF2;
  localparam logic [7:0] PUSH  = 8'hF8;
  localparam logic [7:0] POP   = 8'hF9;

  // Four byte instructions
  localparam logic [7:0] ADDI  = 8'h04;
  localparam logic [7:0] ANDI  = 8'h08;
  localparam logic [7:0] ORI   = 8'h09;
  localparam logic [7:0] JEQZ  = 8'h26;
  localparam logic [7:0] CMPI  = 8'h3B;
  localparam logic [7:0] EXI24 = 8'h52;
  localparam logic [7:0] LDBX  = 8'hB0;
  localparam logic [7:0] STBX  = 8'hC0;

  // Six byte instructions
  localparam logic [7:0] R2    = 8'h02;
  localparam logic [7:0] JMP   = 8'h20;
  localparam logic [7:0] ADDIL = 8'h44;
  localparam logic [7:0] EXI40 = 8'h54;
  localparam logic [7:0] LDO   = 8'h86;
  localparam logic [7:0] STO   = 8'h93;

  // Eight byte instructions, the constant extension prefixes
  localparam logic [7:0] EXI56 = 8'h56;
  localparam logic [7:0] EXIM  = 8'h58;

  // Bytes 8'hD0 to 8'hEF form a block of six byte opcodes and are decoded as a range

endpackage

`default_nettype wire
